/* filelist.f */
source/execPkg.sv
source/aluCore.sv
source/leadCounter.sv
source/resultMerge.sv
source/execUnit.sv
tests/execUnit_asserts.sv
tests/execUnitTb.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - source/execPkg.sv
  - source/aluCore.sv
  - source/leadCounter.sv
  - source/resultMerge.sv
  - source/execUnit.sv
  - target: test
    files:
      - tests/execUnit_asserts.sv
      - tests/execUnitTb.sv

/* tests/execUnitTb.sv */
`timescale 1ns/1ns

// testbench for the integer execute unit
module execUnitTb;

    localparam int Period       = 20;
    localparam int DriveDelay   = 2;
    localparam int FixedVecs    = 30;
    // fixed entries plus clz/clo for every power of two
    localparam int NumVecs      = FixedVecs + 64;
    localparam int RandCycles   = 200;
    localparam int TimeoutCycles = NumVecs + RandCycles + 20;
    localparam logic [31:0] Seed = 32'd35;

    // one table row, request fields plus expected response
    typedef struct packed {
        execPkg::aluOp_e op;
        logic [31:0]     srcA;
        logic [31:0]     srcB;
        logic            ignoreOvf;
        logic [31:0]     expResult;
        logic            expExc;
    } vector_t;

    logic               clk;
    logic               reset;
    execPkg::execReq_t  req;
    execPkg::execResp_t resp;

    vector_t            vecTable [NumVecs];
    logic [31:0]        lfsrState;
    int                 checkCount;
    int                 errorCount;

    // expected contents of the output register
    logic               expValid;
    logic [31:0]        expResult;
    logic               expExc;

    execUnit dut0 (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // hard stop if the sequence never ends
    initial begin
        #(TimeoutCycles * Period);
        $display("timeout: the run did not finish within %0d clock periods", TimeoutCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkResponse();
        checkValue(resp.valid, expValid, "resp.valid");
        checkValue(resp.excOccur, expExc, "resp.excOccur");
        checkValue(resp.result, expResult, "resp.result");
    endtask

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per bit taken
    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // scan from the top while bits match
    function automatic logic [31:0] leadingCount(input logic [31:0] value, input logic bitVal);
        int   cnt;
        logic stop;
        cnt = 0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!stop && value[i] == bitVal) cnt++;
            else stop = 1'b1;
        end
        return cnt;
    endfunction

    // expected {exception, result} from the instruction rules
    function automatic logic [32:0] refModel(input execPkg::aluOp_e op, input logic [31:0] a,
                                             input logic [31:0] b, input logic ign);
        logic [31:0] r;
        logic        ovf;
        ovf = 1'b0;
        r = a;
        case (op)
            execPkg::OpAdd: begin
                r = a + b;
                // same-sign operands, sign flips
                ovf = (a[31] == b[31]) && (r[31] != a[31]);
            end
            execPkg::OpSub: begin
                r = a - b;
                ovf = (a[31] != b[31]) && (r[31] != a[31]);
            end
            execPkg::OpAnd: r = a & b;
            execPkg::OpOr:  r = a | b;
            execPkg::OpXor: r = a ^ b;
            execPkg::OpNor: r = ~(a | b);
            execPkg::OpSll: r = b << a[4:0];
            execPkg::OpSrl: r = b >> a[4:0];
            execPkg::OpSra: r = $signed(b) >>> a[4:0];
            execPkg::OpLui: r = {b[15:0], 16'h0000};
            execPkg::OpLt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            execPkg::OpLtu: r = (a < b) ? 32'd1 : 32'd0;
            execPkg::OpClz: r = leadingCount(a, 1'b0);
            execPkg::OpClo: r = leadingCount(a, 1'b1);
            default:        r = a;
        endcase
        return {ovf & ~ign, r};
    endfunction

    task automatic loadTable();
        // add/sub at the signed limits
        vecTable[0]  = '{execPkg::OpAdd, 32'h7fffffff, 32'h00000001, 1'b0, 32'h80000000, 1'b1};
        vecTable[1]  = '{execPkg::OpAdd, 32'h7fffffff, 32'h00000001, 1'b1, 32'h80000000, 1'b0};
        vecTable[2]  = '{execPkg::OpAdd, 32'h80000000, 32'hffffffff, 1'b0, 32'h7fffffff, 1'b1};
        vecTable[3]  = '{execPkg::OpAdd, 32'h00000005, 32'hfffffffd, 1'b0, 32'h00000002, 1'b0};
        vecTable[4]  = '{execPkg::OpSub, 32'h80000000, 32'h00000001, 1'b0, 32'h7fffffff, 1'b1};
        vecTable[5]  = '{execPkg::OpSub, 32'h7fffffff, 32'hffffffff, 1'b0, 32'h80000000, 1'b1};
        vecTable[6]  = '{execPkg::OpSub, 32'h80000000, 32'h00000001, 1'b1, 32'h7fffffff, 1'b0};
        vecTable[7]  = '{execPkg::OpSub, 32'h00000003, 32'h00000005, 1'b0, 32'hfffffffe, 1'b0};
        // logic ops and pass-through
        vecTable[8]  = '{execPkg::OpAnd, 32'hffffffff, 32'haaaaaaaa, 1'b0, 32'haaaaaaaa, 1'b0};
        vecTable[9]  = '{execPkg::OpOr,  32'h55555555, 32'haaaaaaaa, 1'b0, 32'hffffffff, 1'b0};
        vecTable[10] = '{execPkg::OpXor, 32'hffffffff, 32'h55555555, 1'b0, 32'haaaaaaaa, 1'b0};
        vecTable[11] = '{execPkg::OpNor, 32'h00000000, 32'h00000000, 1'b0, 32'hffffffff, 1'b0};
        vecTable[12] = '{execPkg::OpLui, 32'h55555555, 32'h1234abcd, 1'b0, 32'habcd0000, 1'b0};
        vecTable[13] = '{execPkg::OpPass, 32'hdeadbeef, 32'h00000000, 1'b0, 32'hdeadbeef, 1'b0};
        // amount 33 wraps to 1
        vecTable[14] = '{execPkg::OpSll, 32'h00000021, 32'h00000001, 1'b0, 32'h00000002, 1'b0};
        vecTable[15] = '{execPkg::OpSrl, 32'h00000021, 32'h80000000, 1'b0, 32'h40000000, 1'b0};
        vecTable[16] = '{execPkg::OpSra, 32'h00000004, 32'h80000000, 1'b0, 32'hf8000000, 1'b0};
        vecTable[17] = '{execPkg::OpSra, 32'h0000001f, 32'h7fffffff, 1'b0, 32'h00000000, 1'b0};
        // -1 against 1, signed vs unsigned
        vecTable[18] = '{execPkg::OpLt,  32'hffffffff, 32'h00000001, 1'b0, 32'h00000001, 1'b0};
        vecTable[19] = '{execPkg::OpLtu, 32'hffffffff, 32'h00000001, 1'b0, 32'h00000000, 1'b0};
        vecTable[20] = '{execPkg::OpLt,  32'h00000001, 32'hffffffff, 1'b0, 32'h00000000, 1'b0};
        vecTable[21] = '{execPkg::OpLtu, 32'h00000001, 32'hffffffff, 1'b0, 32'h00000001, 1'b0};
        // count corner cases
        vecTable[22] = '{execPkg::OpClz, 32'h00000000, 32'h00000000, 1'b0, 32'd32, 1'b0};
        vecTable[23] = '{execPkg::OpClo, 32'hffffffff, 32'h00000000, 1'b0, 32'd32, 1'b0};
        vecTable[24] = '{execPkg::OpClz, 32'h80000000, 32'h00000000, 1'b0, 32'd0, 1'b0};
        vecTable[25] = '{execPkg::OpClo, 32'h7fffffff, 32'h00000000, 1'b0, 32'd0, 1'b0};
        vecTable[26] = '{execPkg::OpClz, 32'h00000001, 32'h00000000, 1'b0, 32'd31, 1'b0};
        vecTable[27] = '{execPkg::OpClz, 32'h00010000, 32'h00000000, 1'b0, 32'd15, 1'b0};
        vecTable[28] = '{execPkg::OpClo, 32'hfff00000, 32'h00000000, 1'b0, 32'd12, 1'b0};
        // clo with the overflow mask off, no exception expected
        vecTable[29] = '{execPkg::OpClo, 32'hc0000000, 32'h00000000, 1'b0, 32'd2, 1'b0};
        // every power of two, and its inverse for clo
        for (int k = 0; k < 32; k++) begin
            vecTable[FixedVecs + 2 * k] =
                '{execPkg::OpClz, 32'h1 << k, 32'h0, 1'b0, 31 - k, 1'b0};
            vecTable[FixedVecs + 2 * k + 1] =
                '{execPkg::OpClo, ~(32'h1 << k), 32'h0, 1'b0, 31 - k, 1'b0};
        end
    endtask

    // check last cycle's response, then drive the next request
    task automatic applyCycle(input logic v, input vector_t vec);
        @(posedge clk);
        #(DriveDelay);
        checkResponse();
        req.valid = v;
        req.op = vec.op;
        req.srcA = vec.srcA;
        req.srcB = vec.srcB;
        req.ignoreOvf = vec.ignoreOvf;
        expValid = v;
        expExc = v & vec.expExc;
        // result register holds on idle cycles
        if (v) expResult = vec.expResult;
    endtask

    initial begin
        vector_t     vec;
        logic [31:0] bitsA;
        logic [31:0] bitsB;
        logic [31:0] bitsOp;
        logic [31:0] bitsMode;
        logic [31:0] bitsIgn;
        logic [3:0]  opCode;
        req = '0;
        reset = 1'b1;
        checkCount = 0;
        errorCount = 0;
        lfsrState = Seed;
        expValid = 1'b0;
        expResult = '0;
        expExc = 1'b0;
        loadTable();

        repeat (3) @(posedge clk);
        #(DriveDelay);
        reset = 1'b0;
        // cleared response straight after reset
        checkResponse();

        // directed phase, back to back
        for (int i = 0; i < NumVecs; i++) begin
            applyCycle(1'b1, vecTable[i]);
        end
        // idle gap, valid drops and result holds
        repeat (3) applyCycle(1'b0, vecTable[4]);

        // random phase
        for (int n = 0; n < RandCycles; n++) begin
            drawBits(32, bitsA);
            drawBits(32, bitsB);
            drawBits(4, bitsOp);
            drawBits(3, bitsMode);
            drawBits(2, bitsIgn);
            opCode = bitsOp[3:0] % 4'd15;
            vec.op = execPkg::aluOp_e'(opCode);
            // shift down for varied leading zeros or ones
            if (bitsMode == 1) bitsA = bitsA >> bitsB[4:0];
            if (bitsMode == 2) bitsA = ~(bitsA >> bitsB[4:0]);
            vec.srcA = bitsA;
            vec.srcB = bitsB;
            vec.ignoreOvf = (bitsIgn == 0);
            {vec.expExc, vec.expResult} = refModel(vec.op, vec.srcA, vec.srcB, vec.ignoreOvf);
            // mode 0 is an idle cycle
            applyCycle(bitsMode != 0, vec);
        end
        // drain the last response
        repeat (2) applyCycle(1'b0, vecTable[0]);

        // bound checker failures count against the run as well
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, dut0.asserts0.failCount);
        if (errorCount == 0 && dut0.asserts0.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tests/execUnit_asserts.sv */
`timescale 1ns/1ns

// protocol checks on the execute unit ports
// bound into every execUnit instance
module execUnitAsserts (
    input logic               clk,
    input logic               reset,
    input execPkg::execReq_t  req,
    input execPkg::execResp_t resp
);

    // number of failed assertions, read by the testbench at the end
    int failCount = 0;

    // request strobe gives a response strobe one cycle later
    assert property (@(posedge clk) disable iff (reset) req.valid |=> resp.valid)
        else begin
            $error("response valid missing one cycle after request");
            failCount++;
        end

    // no response strobe without a request
    assert property (@(posedge clk) disable iff (reset) !req.valid |=> !resp.valid)
        else begin
            $error("response valid without a request");
            failCount++;
        end

    // exception only on a valid response
    assert property (@(posedge clk) disable iff (reset) resp.excOccur |-> resp.valid)
        else begin
            $error("excOccur high while resp.valid is low");
            failCount++;
        end

    // output register cleared by reset
    assert property (@(posedge clk) reset |=> !resp.valid)
        else begin
            $error("response valid in the cycle after reset");
            failCount++;
        end

endmodule

bind execUnit execUnitAsserts asserts0 (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .resp  (resp)
);

/* source/execUnit.sv */
`timescale 1ns/1ns

// integer execute unit, top level
// core and counter side by side, merge registers the result
module execUnit (
    input  logic               clk,
    input  logic               reset,
    input  execPkg::execReq_t  req,
    output execPkg::execResp_t resp
);

    // core ALU result and exception
    execPkg::coreOut_t    coreOut;

    // leading counts of srcA
    execPkg::leadCounts_t counts;

    // arithmetic, logic, shift, compare
    aluCore core0 (
        .op        (req.op),
        .srcA      (req.srcA),
        .srcB      (req.srcB),
        .ignoreOvf (req.ignoreOvf),
        .coreOut   (coreOut)
    );

    // clz/clo, runs in parallel with the core
    leadCounter counter0 (
        .srcA   (req.srcA),
        .counts (counts)
    );

    // select and register
    resultMerge merge0 (
        .clk     (clk),
        .reset   (reset),
        .valid   (req.valid),
        .op      (req.op),
        .coreOut (coreOut),
        .counts  (counts),
        .resp    (resp)
    );

endmodule

/* source/resultMerge.sv */
`timescale 1ns/1ns

// picks the core result or a leading count
// then registers the response, one cycle
module resultMerge (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  execPkg::aluOp_e      op,
    input  execPkg::coreOut_t    coreOut,
    input  execPkg::leadCounts_t counts,
    output execPkg::execResp_t   resp
);

    // padding for zero-extending a count
    localparam int PadWidth = execPkg::WordWidth - execPkg::CountWidth;

    // result before the register
    logic [execPkg::WordWidth-1:0] mergedResult;

    // counts override the core for clo/clz
    always_comb begin
        case (op)
            execPkg::OpClo: mergedResult = {{PadWidth{1'b0}}, counts.ones};
            execPkg::OpClz: mergedResult = {{PadWidth{1'b0}}, counts.zeros};
            default:        mergedResult = coreOut.result;
        endcase
    end

    // response register
    // result holds its value on idle cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            resp <= '0;
        end else begin
            // one-cycle valid per request
            resp.valid <= valid;
            // no exception without a request
            resp.excOccur <= valid & coreOut.excOccur;
            if (valid) begin
                resp.result <= mergedResult;
            end
        end
    end

endmodule

/* source/leadCounter.sv */
`timescale 1ns/1ns

// leading-zero and leading-one counts of srcA
// both counts every cycle, opcode not needed here
module leadCounter (
    input  logic [execPkg::WordWidth-1:0] srcA,
    output execPkg::leadCounts_t          counts
);

    // leading zeros by binary halving, 0 to 32
    function automatic logic [execPkg::CountWidth-1:0] countLeadZeros(
        input logic [execPkg::WordWidth-1:0] value
    );
        logic [execPkg::CountWidth-1:0] cnt;
        logic [15:0]                    val16;
        logic [7:0]                     val8;
        logic [3:0]                     val4;
        // whole word zero, count is 32
        cnt[5] = (value == '0);
        // upper half empty, keep lower half
        cnt[4] = (value[31:16] == 16'h0000) & ~cnt[5];
        val16  = cnt[4] ? value[15:0] : value[31:16];
        cnt[3] = (val16[15:8] == 8'h00) & ~cnt[5];
        val8   = cnt[3] ? val16[7:0] : val16[15:8];
        cnt[2] = (val8[7:4] == 4'h0) & ~cnt[5];
        val4   = cnt[2] ? val8[3:0] : val8[7:4];
        cnt[1] = (val4[3:2] == 2'b00) & ~cnt[5];
        // last bit of the remaining pair
        cnt[0] = cnt[1] ? (~val4[1] & ~cnt[5]) : (~val4[3] & ~cnt[5]);
        return cnt;
    endfunction

    // zeros straight from the operand
    assign counts.zeros = countLeadZeros(srcA);

    // leading ones are leading zeros of the inverted word
    assign counts.ones = countLeadZeros(~srcA);

endmodule

/* source/aluCore.sv */
`timescale 1ns/1ns

// arithmetic, logic, shift and compare unit
// purely combinational, overflow exception for add and sub
module aluCore (
    input  execPkg::aluOp_e                 op,
    input  logic [execPkg::WordWidth-1:0]   srcA,
    input  logic [execPkg::WordWidth-1:0]   srcB,
    input  logic                            ignoreOvf,
    output execPkg::coreOut_t               coreOut
);

    // sign-extended sum and difference, one extra bit
    logic [execPkg::WordWidth:0]   sumExt;
    logic [execPkg::WordWidth:0]   diffExt;

    // shift amount, low five bits of srcA only
    logic [4:0]                    shiftAmt;

    // compare results
    logic                          lessSigned;
    logic                          lessUnsigned;

    // overflow before masking
    logic                          addOvf;
    logic                          subOvf;

    assign sumExt  = {srcA[execPkg::WordWidth-1], srcA} + {srcB[execPkg::WordWidth-1], srcB};
    assign diffExt = {srcA[execPkg::WordWidth-1], srcA} - {srcB[execPkg::WordWidth-1], srcB};

    assign shiftAmt = srcA[4:0];

    // extra bit of the extended difference is the true sign
    assign lessSigned = diffExt[execPkg::WordWidth];

    // plain unsigned compare, not bit 31 of the difference
    assign lessUnsigned = (srcA < srcB);

    // top two bits disagree on signed overflow
    assign addOvf = sumExt[execPkg::WordWidth] ^ sumExt[execPkg::WordWidth-1];
    assign subOvf = diffExt[execPkg::WordWidth] ^ diffExt[execPkg::WordWidth-1];

    // result select
    always_comb begin
        case (op)
            execPkg::OpAdd: coreOut.result = sumExt[execPkg::WordWidth-1:0];
            execPkg::OpSub: coreOut.result = diffExt[execPkg::WordWidth-1:0];
            execPkg::OpAnd: coreOut.result = srcA & srcB;
            execPkg::OpOr:  coreOut.result = srcA | srcB;
            execPkg::OpXor: coreOut.result = srcA ^ srcB;
            execPkg::OpNor: coreOut.result = ~(srcA | srcB);
            execPkg::OpSll: coreOut.result = srcB << shiftAmt;
            // arithmetic shift keeps srcB sign
            execPkg::OpSra: coreOut.result = $signed(srcB) >>> shiftAmt;
            execPkg::OpSrl: coreOut.result = srcB >> shiftAmt;
            // low half of srcB into the upper half
            execPkg::OpLui: begin
                coreOut.result = {srcB[execPkg::WordWidth/2-1:0],
                                  {(execPkg::WordWidth/2){1'b0}}};
            end
            execPkg::OpLt: begin
                coreOut.result = {{(execPkg::WordWidth-1){1'b0}}, lessSigned};
            end
            execPkg::OpLtu: begin
                coreOut.result = {{(execPkg::WordWidth-1){1'b0}}, lessUnsigned};
            end
            // counts are substituted later in the merge stage
            execPkg::OpClo:  coreOut.result = srcA;
            execPkg::OpClz:  coreOut.result = srcA;
            execPkg::OpPass: coreOut.result = srcA;
            // unused encoding behaves as pass
            default: coreOut.result = srcA;
        endcase
    end

    // exception only for add/sub, masked by ignoreOvf
    always_comb begin
        coreOut.excOccur = 1'b0;
        if (!ignoreOvf) begin
            if (op == execPkg::OpAdd) begin
                coreOut.excOccur = addOvf;
            end else if (op == execPkg::OpSub) begin
                coreOut.excOccur = subOvf;
            end
        end
    end

endmodule

/* source/execPkg.sv */
// shared types for the integer execute unit
package execPkg;

    // operand and result width, fixed by the instruction set
    localparam int WordWidth = 32;

    // leading count spans 0 to 32, so six bits
    localparam int CountWidth = 6;

    // execute opcodes
    typedef enum logic [3:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        OpNor,
        OpSll,
        OpSra,
        OpSrl,
        OpLui,
        OpLt,
        OpLtu,
        OpClo,
        OpClz,
        OpPass
    } aluOp_e;

    // request from the issue stage, one-cycle strobe
    typedef struct packed {
        logic                 valid;
        aluOp_e               op;
        logic [WordWidth-1:0] srcA;
        logic [WordWidth-1:0] srcB;
        // masks the add/sub overflow exception
        logic                 ignoreOvf;
    } execReq_t;

    // registered response, one cycle after the request
    typedef struct packed {
        logic                 valid;
        logic [WordWidth-1:0] result;
        logic                 excOccur;
    } execResp_t;

    // combinational output of the core ALU
    typedef struct packed {
        logic [WordWidth-1:0] result;
        logic                 excOccur;
    } coreOut_t;

    // leading counts of the first operand
    typedef struct packed {
        logic [CountWidth-1:0] zeros;
        logic [CountWidth-1:0] ones;
    } leadCounts_t;

endpackage
